// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_seed_frontend
FILELIST  := build.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard src/*.sv) $(wildcard dv/*.sv)
PASS_MSG  := Simulation finished: PASS

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM) 2>&1)"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
src/seed_pkg.sv
src/pc_sequencer.sv
src/fetch_port.sv
src/instr_decode.sv
src/shift_multiplier.sv
src/restoring_divider.sv
src/seed_frontend.sv
dv/seed_frontend_asserts.sv
dv/tb_seed_frontend.sv

// File: dv/seed_frontend_asserts.sv
module seed_frontend_asserts (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      fetch_req,
    input logic [seed_pkg::xlen-1:0] fetch_addr,
    input logic                      fetch_valid,
    input logic                      wb_valid
);
    timeunit 1ns;
    timeprecision 100ps;

    logic outstanding;

    // one read in flight from the request until the returned word
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            outstanding <= 1'b0;
        end else if (fetch_req) begin
            outstanding <= 1'b1;
        end else if (fetch_valid) begin
            outstanding <= 1'b0;
        end
    end

    a_one_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
        outstanding |-> !fetch_req) else $error("second fetch while a read is outstanding");
    a_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_req |-> (fetch_addr[1:0] == 2'b00)) else $error("fetch address not word aligned");
    a_wb_single: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |=> !wb_valid) else $error("write-back strobe longer than one cycle");
    a_reset_quiet: assert property (@(posedge clk)
        $rose(rst_n) |=> !fetch_req) else $error("fetch issued in the cycle after reset release");

endmodule

bind seed_frontend seed_frontend_asserts u_seed_frontend_asserts (
    .clk         (clk),
    .rst_n       (rst_n),
    .fetch_req   (fetch_req),
    .fetch_addr  (fetch_addr),
    .fetch_valid (fetch_valid),
    .wb_valid    (wb_valid)
);

// File: dv/tb_seed_frontend.sv
module tb_seed_frontend;
    timeunit 1ns;
    timeprecision 100ps;
    import seed_pkg::*;

    localparam int n_instr = 18;
    localparam int timeout_cycles = n_instr * (mul_cycles + 8) + 100;
    localparam logic [6:0] op_plain = 7'b001_0011;

    logic clk, rst_n, fetch_req, fetch_valid, wb_valid;
    logic [xlen-1:0] fetch_addr, fetch_data, rs1_data, rs2_data, wb_data;
    logic [4:0] rs1_addr, rs2_addr, wb_rd, wr_rd;
    logic [xlen-1:0] regs [32];
    logic [xlen-1:0] mem [logic [xlen-1:0]];
    logic [31:0] lcg_state = 32'h221c_3748;
    logic [xlen-1:0] cur_pc, wr_data;
    int cyc = 0;
    int valid_cyc = 0;
    int rst_cyc = 0;

    seed_frontend u_seed_frontend (.*);

    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

    always #20 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // untouched locations hold plain instructions that vary with the address
    function automatic logic [31:0] mem_read(input logic [xlen-1:0] a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return {a[31:7] ^ a[24:0], op_plain};
    endfunction

    task automatic stop_fail(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_addr(input logic [xlen-1:0] got, input logic [xlen-1:0] exp);
        if (got !== exp) begin
            stop_fail($sformatf("ERROR @%0t: fetch_addr %h, expected %h", $time, got, exp));
        end
    endtask

    task automatic check_wb(input logic [4:0] got_rd, input logic [xlen-1:0] got_data,
                            input logic [4:0] exp_rd, input logic [xlen-1:0] exp_data);
        if (got_rd !== exp_rd || got_data !== exp_data) begin
            stop_fail($sformatf("ERROR @%0t: write-back x%0d=%h, expected x%0d=%h",
                                $time, got_rd, got_data, exp_rd, exp_data));
        end
    endtask

    task automatic check_cycles(input int got, input int exp, input string what);
        if (got != exp) begin
            stop_fail($sformatf("ERROR @%0t: %s took %0d cycles, expected %0d",
                                $time, what, got, exp));
        end
    endtask

    // ==================================================
    // memory, register file and run limit
    // ==================================================
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= timeout_cycles) begin
            stop_fail("timeout: the DUT stopped making progress");
        end
    end

    always begin
        logic [xlen-1:0] addr;
        logic [31:0] r;
        @(negedge clk);
        if (fetch_req) begin
            addr = fetch_addr;
            r = lcg_next();
            repeat (1 + int'(r[17:16] % 2'd3)) @(posedge clk);
            #2;
            fetch_valid = 1'b1;
            fetch_data  = mem_read(addr);
            valid_cyc   = cyc;
            @(posedge clk);
            #2;
            fetch_valid = 1'b0;
        end
    end

    // writes land just after the edge, like a clocked register file
    always begin
        @(negedge clk);
        if (wb_valid && wb_rd != 5'd0) begin
            wr_rd   = wb_rd;
            wr_data = wb_data;
            @(posedge clk);
            #1;
            regs[wr_rd] = wr_data;
        end
    end

    // ==================================================
    // instruction runner and directed tests
    // ==================================================
    task automatic exec_instr(input logic [31:0] word, input logic [xlen-1:0] next_pc,
                              input logic wb_exp, input logic [4:0] rd_exp,
                              input logic [xlen-1:0] data_exp, input logic unit);
        bit wb_seen;
        int wb_cyc;
        wb_seen = 0;
        wb_cyc = 0;
        mem[cur_pc] = word;
        do begin
            @(negedge clk);
            if (wb_valid) begin
                if (!wb_exp) begin
                    stop_fail("write-back strobe from an instruction with no result");
                end
                check_wb(wb_rd, wb_data, rd_exp, data_exp);
                wb_seen = 1;
                wb_cyc = cyc;
            end
        end while (!fetch_req);
        if (wb_exp && !wb_seen) begin
            stop_fail("expected write-back strobe never came");
        end
        check_addr(fetch_addr, next_pc);
        if (unit) begin
            check_cycles(wb_cyc - valid_cyc, mul_cycles + 2, "unit write-back");
            check_cycles(cyc - wb_cyc, 1, "fetch after unit write-back");
        end else begin
            check_cycles(cyc - valid_cyc, 2, "next fetch");
            if (wb_exp) begin
                check_cycles(wb_cyc - valid_cyc, 1, "link write-back");
            end
        end
        cur_pc = next_pc;
    endtask

    task automatic test_sequential();
        repeat (5) exec_instr({12'h001, 5'd0, 3'd0, 5'd5, op_plain}, cur_pc + 4, 0, 0, 0, 0);
    endtask

    task automatic test_jumps();
        logic [20:0] j;
        j = 21'h00_0040;
        exec_instr({j[20], j[10:1], j[11], j[19:12], 5'd1, op_jal}, cur_pc + {{11{j[20]}}, j},
                   1, 5'd1, cur_pc + 4, 0);
        regs[6] = cur_pc + 32'h100;
        exec_instr({12'h011, 5'd6, 3'd0, 5'd2, op_jalr}, (regs[6] + 32'h11) & ~32'h1,
                   1, 5'd2, cur_pc + 4, 0);
        exec_instr({12'hff8, 5'd6, 3'd0, 5'd2, op_jalr}, (regs[6] - 32'h8) & ~32'h1,
                   1, 5'd2, cur_pc + 4, 0);
    endtask

    task automatic run_branch(input logic [2:0] f3, input logic [4:0] rs2,
                              input logic [12:0] b, input logic taken);
        exec_instr({b[12], b[10:5], rs2, 5'd7, f3, b[4:1], b[11], op_branch},
                   taken ? cur_pc + {{19{b[12]}}, b} : cur_pc + 4, 0, 0, 0, 0);
    endtask

    task automatic test_branches();
        regs[7] = lcg_next();
        regs[8] = regs[7] ^ 32'h1;
        run_branch(f3_beq, 5'd7, 13'h0020, 1);
        run_branch(f3_beq, 5'd8, 13'h0020, 0);
        run_branch(f3_bne, 5'd8, 13'h1ff0, 1);
        run_branch(f3_bne, 5'd7, 13'h1ff0, 0);
    endtask

    task automatic run_unit(input logic [2:0] f3, input logic [4:0] rd,
                            input logic [xlen-1:0] a, input logic [xlen-1:0] b);
        logic [63:0] prod;
        logic [xlen-1:0] exp;
        regs[10] = a;
        regs[11] = b;
        prod = {32'b0, a} * {32'b0, b};
        if (f3 == f3_mul) begin
            exp = prod[31:0];
        end else if (b == 0) begin
            exp = (f3 == f3_divu) ? '1 : a;
        end else begin
            exp = (f3 == f3_divu) ? a / b : a % b;
        end
        exec_instr({f7_muldiv, 5'd11, 5'd10, f3, rd, op_op}, cur_pc + 4, 1, rd, exp, 1);
    endtask

    task automatic test_muldiv();
        run_unit(f3_mul, 5'd12, lcg_next(), lcg_next());
        run_unit(f3_mul, 5'd13, lcg_next(), lcg_next());
        run_unit(f3_divu, 5'd14, lcg_next(), lcg_next() >> 16);
        run_unit(f3_remu, 5'd15, lcg_next(), lcg_next() >> 20);
        run_unit(f3_divu, 5'd16, lcg_next(), 32'h0);
        run_unit(f3_remu, 5'd17, lcg_next(), 32'h0);
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        fetch_valid = 1'b0;
        fetch_data = '0;
        regs[0] = '0;
        for (int i = 1; i < 32; i++) begin
            regs[i] = lcg_next();
        end
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;
        rst_cyc = cyc;
        do @(negedge clk); while (!fetch_req);
        check_cycles(cyc - rst_cyc, 2, "first fetch after reset");
        check_addr(fetch_addr, reset_pc);
        cur_pc = reset_pc;
        test_sequential();
        test_jumps();
        test_branches();
        test_muldiv();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: src/fetch_port.sv
module fetch_port (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      fetch_start,
    input  logic [seed_pkg::xlen-1:0] pc,
    output logic                      fetch_req,
    output logic [seed_pkg::xlen-1:0] fetch_addr,
    input  logic                      fetch_valid,
    input  logic [seed_pkg::xlen-1:0] fetch_data,
    output seed_pkg::instr_word_u     instr,
    output logic                      instr_ready
);

    logic pending;
    logic take_word;

    assign take_word = fetch_valid && pending;

    // the sequencer moves its pc on the same edge that raises fetch_req,
    // and holds it until the word is back
    assign fetch_addr = pc;

    // ==================================================
    // request strobe and outstanding read
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_req   <= 1'b0;
            pending     <= 1'b0;
            instr_ready <= 1'b0;
        end else begin
            fetch_req   <= fetch_start && !pending && !fetch_req;
            instr_ready <= take_word;
            if (fetch_req) begin
                pending <= 1'b1;
            end else if (fetch_valid) begin
                pending <= 1'b0;
            end
        end
    end

    // returned word, held for the decoder
    always_ff @(posedge clk) begin
        if (take_word) begin
            instr <= fetch_data;
        end
    end

endmodule

// File: src/instr_decode.sv
module instr_decode (
    input  seed_pkg::instr_word_u     instr,
    input  logic [seed_pkg::xlen-1:0] pc,
    input  logic [seed_pkg::xlen-1:0] rs1_data,
    input  logic [seed_pkg::xlen-1:0] rs2_data,
    output logic [4:0]                rs1_addr,
    output logic [4:0]                rs2_addr,
    output logic [4:0]                rd,
    output seed_pkg::iclass_e         iclass,
    output logic [seed_pkg::xlen-1:0] target_pc,
    output logic                      take_target,
    output logic [seed_pkg::xlen-1:0] link_pc
);
    import seed_pkg::*;

    logic [xlen-1:0] raw;
    logic [xlen-1:0] imm_j;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] jalr_sum;
    logic            operands_eq;

    assign raw = instr;

    assign rs1_addr = instr.r.rs1;
    assign rs2_addr = instr.r.rs2;
    assign rd       = instr.r.rd;
    assign link_pc  = pc + xlen'(4);

    // ==================================================
    // immediates and targets
    // ==================================================
    assign imm_j = {{11{raw[31]}}, raw[31], raw[19:12], raw[20], raw[30:21], 1'b0};
    assign imm_b = {{19{raw[31]}}, raw[31], raw[7], raw[30:25], raw[11:8], 1'b0};
    assign imm_i = {{20{instr.i.imm12[11]}}, instr.i.imm12};

    assign jalr_sum    = rs1_data + imm_i;
    assign operands_eq = (rs1_data == rs2_data);

    // ==================================================
    // classification
    // ==================================================
    always_comb begin
        iclass      = ic_plain;
        take_target = 1'b0;
        target_pc   = pc + imm_b;
        case (instr.r.opcode)
            op_jal: begin
                iclass      = ic_jal;
                take_target = 1'b1;
                target_pc   = pc + imm_j;
            end
            op_jalr: begin
                iclass      = ic_jalr;
                take_target = 1'b1;
                target_pc   = {jalr_sum[xlen-1:1], 1'b0};
            end
            op_branch: begin
                // only beq and bne are handled, the other compares run as plain
                if (instr.r.funct3 == f3_beq) begin
                    iclass      = ic_branch;
                    take_target = operands_eq;
                end else if (instr.r.funct3 == f3_bne) begin
                    iclass      = ic_branch;
                    take_target = !operands_eq;
                end
            end
            op_op: begin
                if (instr.r.funct7 == f7_muldiv) begin
                    case (instr.r.funct3)
                        f3_mul:  iclass = ic_mul;
                        f3_divu: iclass = ic_divu;
                        f3_remu: iclass = ic_remu;
                        default: iclass = ic_plain;
                    endcase
                end
            end
            default: begin
                iclass = ic_plain;
            end
        endcase
    end

endmodule

// File: src/pc_sequencer.sv
module pc_sequencer (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      instr_ready,
    input  seed_pkg::iclass_e         iclass,
    input  logic [seed_pkg::xlen-1:0] target_pc,
    input  logic                      take_target,
    input  logic                      mul_done,
    input  logic                      div_done,
    input  logic [seed_pkg::xlen-1:0] mul_result,
    input  logic [seed_pkg::xlen-1:0] div_quot,
    input  logic [seed_pkg::xlen-1:0] div_rem,
    input  logic [seed_pkg::xlen-1:0] link_pc,
    input  logic [4:0]                rd,
    output logic [seed_pkg::xlen-1:0] pc,
    output logic                      fetch_start,
    output logic                      mul_start,
    output logic                      div_start,
    output logic                      wb_valid,
    output logic [4:0]                wb_rd,
    output logic [seed_pkg::xlen-1:0] wb_data
);
    import seed_pkg::*;

    logic [1:0]      state;
    iclass_e         class_q;
    logic [4:0]      rd_q;
    logic            first_fetch;
    logic            instr_go;
    logic            to_unit;
    logic            unit_done;
    logic [xlen-1:0] unit_data;

    // ==================================================
    // decisions taken in the cycle the word is decoded
    // ==================================================
    assign instr_go  = (state == st_wait_instr) && instr_ready;
    assign to_unit   = (iclass == ic_mul) || (iclass == ic_divu) || (iclass == ic_remu);
    assign unit_done = (state == st_wait_unit) &&
                       ((class_q == ic_mul) ? mul_done : div_done);

    // the first fetch leaves in the cycle after the idle state
    assign fetch_start = first_fetch || (instr_go && !to_unit) || unit_done;
    assign mul_start   = instr_go && (iclass == ic_mul);
    assign div_start   = instr_go && ((iclass == ic_divu) || (iclass == ic_remu));

    assign wb_valid = (instr_go && ((iclass == ic_jal) || (iclass == ic_jalr))) || unit_done;
    assign wb_rd    = unit_done ? rd_q : rd;

    always_comb begin
        case (class_q)
            ic_mul:  unit_data = mul_result;
            ic_divu: unit_data = div_quot;
            default: unit_data = div_rem;
        endcase
    end

    assign wb_data = unit_done ? unit_data : link_pc;

    // ==================================================
    // state and program counter
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= st_idle;
            pc          <= reset_pc;
            class_q     <= ic_plain;
            first_fetch <= 1'b0;
        end else begin
            first_fetch <= (state == st_idle);
            case (state)
                st_idle: begin
                    state <= st_wait_instr;
                end
                st_wait_instr: begin
                    if (instr_go) begin
                        class_q <= iclass;
                        // pc stays on the mul/div until its result is written
                        if (to_unit) begin
                            state <= st_wait_unit;
                        end else if (take_target) begin
                            pc <= target_pc;
                        end else begin
                            pc <= pc + xlen'(4);
                        end
                    end
                end
                st_wait_unit: begin
                    if (unit_done) begin
                        state <= st_wait_instr;
                        pc    <= pc + xlen'(4);
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (instr_go) begin
            rd_q <= rd;
        end
    end

endmodule

// File: src/restoring_divider.sv
module restoring_divider (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  logic [seed_pkg::xlen-1:0] dividend,
    input  logic [seed_pkg::xlen-1:0] divisor,
    output logic                      done,
    output logic [seed_pkg::xlen-1:0] quotient,
    output logic [seed_pkg::xlen-1:0] remainder
);
    import seed_pkg::*;

    logic             busy;
    logic [cnt_w-1:0] count;
    logic [xlen-1:0]  dsor;
    logic [xlen:0]    partial;
    logic [xlen:0]    trial;
    logic             fits;

    // ==================================================
    // one shift-subtract step
    // ==================================================
    // the next dividend bit comes off the top of the quotient register
    assign partial = {remainder, quotient[xlen-1]};
    assign trial   = partial - {1'b0, dsor};
    assign fits    = (partial >= {1'b0, dsor});

    // a zero divisor always fits, so the quotient fills with ones and
    // the remainder ends up equal to the dividend

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            count <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy  <= 1'b1;
                count <= '0;
            end else if (busy) begin
                count <= count + 1'b1;
                if (count == cnt_w'(mul_cycles - 1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            dsor      <= divisor;
            quotient  <= dividend;
            remainder <= '0;
        end else if (busy) begin
            // a failed trial keeps the shifted partial, which is the restore
            remainder <= fits ? trial[xlen-1:0] : partial[xlen-1:0];
            quotient  <= {quotient[xlen-2:0], fits};
        end
    end

endmodule

// File: src/seed_frontend.sv
module seed_frontend (
    input  logic                      clk,
    input  logic                      rst_n,
    output logic                      fetch_req,
    output logic [seed_pkg::xlen-1:0] fetch_addr,
    input  logic                      fetch_valid,
    input  logic [seed_pkg::xlen-1:0] fetch_data,
    output logic [4:0]                rs1_addr,
    output logic [4:0]                rs2_addr,
    input  logic [seed_pkg::xlen-1:0] rs1_data,
    input  logic [seed_pkg::xlen-1:0] rs2_data,
    output logic                      wb_valid,
    output logic [4:0]                wb_rd,
    output logic [seed_pkg::xlen-1:0] wb_data
);
    import seed_pkg::*;

    logic [xlen-1:0] pc;
    logic            fetch_start;
    instr_word_u     instr;
    logic            instr_ready;
    iclass_e         iclass;
    logic [xlen-1:0] target_pc;
    logic            take_target;
    logic [xlen-1:0] link_pc;
    logic [4:0]      rd;
    logic            mul_start;
    logic            div_start;
    logic            mul_done;
    logic            div_done;
    logic [xlen-1:0] mul_result;
    logic [xlen-1:0] div_quot;
    logic [xlen-1:0] div_rem;

    pc_sequencer u_pc_sequencer (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_ready (instr_ready),
        .iclass      (iclass),
        .target_pc   (target_pc),
        .take_target (take_target),
        .mul_done    (mul_done),
        .div_done    (div_done),
        .mul_result  (mul_result),
        .div_quot    (div_quot),
        .div_rem     (div_rem),
        .link_pc     (link_pc),
        .rd          (rd),
        .pc          (pc),
        .fetch_start (fetch_start),
        .mul_start   (mul_start),
        .div_start   (div_start),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

    fetch_port u_fetch_port (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_start (fetch_start),
        .pc          (pc),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .fetch_valid (fetch_valid),
        .fetch_data  (fetch_data),
        .instr       (instr),
        .instr_ready (instr_ready)
    );

    instr_decode u_instr_decode (
        .instr       (instr),
        .pc          (pc),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .rd          (rd),
        .iclass      (iclass),
        .target_pc   (target_pc),
        .take_target (take_target),
        .link_pc     (link_pc)
    );

    // both units take their operands straight from the register file read
    shift_multiplier u_shift_multiplier (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (mul_start),
        .a       (rs1_data),
        .b       (rs2_data),
        .done    (mul_done),
        .product (mul_result)
    );

    restoring_divider u_restoring_divider (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (div_start),
        .dividend  (rs1_data),
        .divisor   (rs2_data),
        .done      (div_done),
        .quotient  (div_quot),
        .remainder (div_rem)
    );

endmodule

// File: src/seed_pkg.sv
package seed_pkg;

    // ==================================================
    // widths, reset values and iteration counts
    // ==================================================
    localparam int xlen = 32;
    localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;
    localparam int mul_cycles = 32;
    localparam int cnt_w = $clog2(mul_cycles);

    // sequencer states
    localparam logic [1:0] st_idle       = 2'd0;
    localparam logic [1:0] st_wait_instr = 2'd1;
    localparam logic [1:0] st_wait_unit  = 2'd2;

    // ==================================================
    // opcode and function codes
    // ==================================================
    localparam logic [6:0] op_jal    = 7'b110_1111;
    localparam logic [6:0] op_jalr   = 7'b110_0111;
    localparam logic [6:0] op_branch = 7'b110_0011;
    localparam logic [6:0] op_op     = 7'b011_0011;

    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_mul  = 3'b000;
    localparam logic [2:0] f3_divu = 3'b101;
    localparam logic [2:0] f3_remu = 3'b111;

    localparam logic [6:0] f7_muldiv = 7'b000_0001;

    typedef enum logic [2:0] {
        ic_plain,
        ic_jal,
        ic_jalr,
        ic_branch,
        ic_mul,
        ic_divu,
        ic_remu
    } iclass_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fields_s;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fields_s;

    // one fetched word, seen as R format or as I format
    typedef union packed {
        r_fields_s r;
        i_fields_s i;
    } instr_word_u;

endpackage

// File: src/shift_multiplier.sv
module shift_multiplier (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  logic [seed_pkg::xlen-1:0] a,
    input  logic [seed_pkg::xlen-1:0] b,
    output logic                      done,
    output logic [seed_pkg::xlen-1:0] product
);
    import seed_pkg::*;

    logic             busy;
    logic [cnt_w-1:0] count;
    logic [xlen-1:0]  mcand;
    logic [xlen-1:0]  mplier;
    logic [xlen-1:0]  sum_next;

    // bits shifted past the top of mcand only reach the upper product half
    assign sum_next = mplier[0] ? (product + mcand) : product;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            count <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy  <= 1'b1;
                count <= '0;
            end else if (busy) begin
                count <= count + 1'b1;
                if (count == cnt_w'(mul_cycles - 1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mcand   <= a;
            mplier  <= b;
            product <= '0;
        end else if (busy) begin
            product <= sum_next;
            mcand   <= mcand << 1;
            mplier  <= mplier >> 1;
        end
    end

endmodule
